// File: logic/ns_pkg.sv
package ns_pkg;

	// message field widths
	localparam int ADDR_W = 6;
	localparam int DATA_W = 8;
	localparam int REDUN_W = 4;

	// one message on a link, 18 bits
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [REDUN_W-1:0] redun;
	} msg_t;

	// status led positions
	localparam int LED_RUN = 0;
	localparam int LED_DONE = 1;
	localparam int LED_ERR = 2;
	localparam int LED_FULL = 3;

	// shown on both digits while every led is dark
	localparam logic [3:0] IDLE_DIGIT = 4'hA;

	// data rule: zero-extended address xor 5A
	function automatic logic [DATA_W-1:0] msg_data(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] wide;
		wide = {{(DATA_W-ADDR_W){1'b0}}, addr};
		return wide ^ 8'h5A;
	endfunction

	// redundancy rule: high nibble xor low nibble
	function automatic logic [REDUN_W-1:0] msg_redun(input logic [DATA_W-1:0] data);
		return data[7:4] ^ data[3:0];
	endfunction

endpackage

// File: logic/ns_link_if.sv
interface ns_link_if;
	import ns_pkg::*;

	// payload, held by the sender while req is up
	msg_t msg;
	// sender has a message
	logic req;
	// receiver can take one, may rise before req
	logic ack;

	// transfer on any edge with req and ack both high

	modport snd (
		output msg,
		output req,
		input  ack
	);

	modport rcv (
		input  msg,
		input  req,
		output ack
	);

endinterface

// File: logic/tick_gen.sv
module tick_gen #(
	parameter int TICK_DIV = 8
) (
	input  logic i_clk,
	input  logic i_rst_n,
	output logic o_tick
);

	// at least one bit even for a divide by one
	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [CNT_W-1:0] cnt;
	logic wrap;

	// last count of the period
	assign wrap = (cnt == CNT_W'(TICK_DIV - 1));

	// free-running divide counter
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= '0;
		end else if (wrap) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// pulse while counter sits at zero
	// so the first tick comes one cycle after reset
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_tick <= 1'b0;
		end else begin
			o_tick <= (cnt == '0);
		end
	end

endmodule

// File: logic/msg_fifo.sv
module msg_fifo #(
	parameter int DEPTH = 4
) (
	input  logic   i_clk,
	input  logic   i_rst_n,
	ns_link_if.rcv i_wr,
	ns_link_if.snd o_rd,
	output logic   o_full
);
	import ns_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// circular message storage
	msg_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic wr_en;
	logic rd_en;

	assign full = (count == CNT_W'(DEPTH));
	assign o_full = full;

	// write side acks on own state only
	assign i_wr.ack = !full;
	assign wr_en = i_wr.req && i_wr.ack;

	// read side offers the head whenever something is stored
	assign o_rd.req = (count != '0);
	assign o_rd.msg = mem[rd_ptr];
	assign rd_en = o_rd.req && o_rd.ack;

	always_ff @(posedge i_clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= i_wr.msg;
		end
	end

	// pointers wrap at DEPTH for any depth
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// occupancy count unchanged when both sides move
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			count <= '0;
		end else begin
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/fifo_tester.sv
module fifo_tester #(
	parameter int MIN_ADDR = 0,
	parameter int MAX_ADDR = 55
) (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_switch_1,
	input  logic       i_switch_2,
	input  logic       i_tick,
	input  logic       i_full,
	ns_link_if.snd     o_msg,
	ns_link_if.rcv     i_msg,
	output logic [3:0] o_leds,
	output logic [3:0] o_digit0,
	output logic [3:0] o_digit1
);
	import ns_pkg::*;

	// bit 0 is switch 1, bit 1 is switch 2
	logic [1:0] sw_meta;
	logic [1:0] sw_sync;
	logic [1:0] sw_prev;
	logic [1:0] sw_rise;
	logic restart;
	logic arm_hit;

	logic flushing;
	logic src_req;
	logic src_last;
	logic src_start;
	logic src_xfer;
	logic [ADDR_W-1:0] src_addr;
	logic corrupt_arm;
	logic corrupt_cur;
	logic [DATA_W-1:0] src_data;
	msg_t src_msg;

	logic running;
	logic err;
	logic done;
	logic full_seen;
	logic rcv_xfer;
	logic rcv_bad;
	logic [ADDR_W-1:0] exp_addr;
	logic [ADDR_W-1:0] last_addr;
	logic [DATA_W-1:0] last_wide;

	// two flop sync then edge detect
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sw_meta <= '0;
			sw_sync <= '0;
			sw_prev <= '0;
		end else begin
			sw_meta <= {i_switch_2, i_switch_1};
			sw_sync <= sw_meta;
			sw_prev <= sw_sync;
		end
	end

	assign sw_rise = sw_sync & ~sw_prev;
	assign arm_hit = sw_rise[0];
	assign restart = sw_rise[1];

	// new run only when idle, drained and not yet sent
	assign src_start = !restart && !flushing && !src_req && !src_last;
	assign src_xfer = src_req && o_msg.ack;

	// bit 0 flipped on the one corrupted message
	// redundancy stays from clean data
	assign src_data = msg_data(src_addr) ^ {{(DATA_W-1){1'b0}}, corrupt_cur};
	assign src_msg = '{addr: src_addr, data: src_data, redun: msg_redun(msg_data(src_addr))};
	assign o_msg.msg = src_msg;
	assign o_msg.req = src_req;

	// message source
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			flushing <= 1'b0;
			src_req <= 1'b0;
			src_last <= 1'b0;
			src_addr <= ADDR_W'(MIN_ADDR);
			corrupt_arm <= 1'b0;
			corrupt_cur <= 1'b0;
		end else begin
			if (restart) begin
				// held message finishes during flush
				flushing <= 1'b1;
				src_last <= 1'b0;
				corrupt_arm <= 1'b0;
			end else if (flushing) begin
				if (src_xfer) begin
					src_req <= 1'b0;
				end else if (!src_req && !i_msg.req) begin
					// fifo empty, old messages gone
					flushing <= 1'b0;
				end
			end else if (src_start) begin
				src_req <= 1'b1;
				src_addr <= ADDR_W'(MIN_ADDR);
				corrupt_cur <= corrupt_arm;
				corrupt_arm <= 1'b0;
			end else if (src_xfer) begin
				if (src_addr == ADDR_W'(MAX_ADDR)) begin
					src_req <= 1'b0;
					src_last <= 1'b1;
				end else begin
					src_addr <= src_addr + 1'b1;
					// corruption picked up only on a fresh message
					corrupt_cur <= corrupt_arm;
					corrupt_arm <= 1'b0;
				end
			end
			// a press wins over the clear above
			if (arm_hit && !restart) begin
				corrupt_arm <= 1'b1;
			end
		end
	end

	// sink takes one per tick, drains freely in flush
	assign i_msg.ack = flushing || (i_tick && running);
	assign rcv_xfer = i_msg.req && i_msg.ack;

	// any field off the rules
	assign rcv_bad = (i_msg.msg.addr != exp_addr)
		|| (i_msg.msg.data != msg_data(exp_addr))
		|| (i_msg.msg.redun != msg_redun(i_msg.msg.data));

	// sink and checker
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			running <= 1'b0;
			err <= 1'b0;
			done <= 1'b0;
			full_seen <= 1'b0;
			exp_addr <= ADDR_W'(MIN_ADDR);
			last_addr <= '0;
		end else if (restart) begin
			running <= 1'b0;
			err <= 1'b0;
			done <= 1'b0;
			full_seen <= 1'b0;
			exp_addr <= ADDR_W'(MIN_ADDR);
		end else begin
			if (src_start) begin
				running <= 1'b1;
			end
			if (i_full) begin
				full_seen <= 1'b1;
			end
			if (running && rcv_xfer) begin
				last_addr <= i_msg.msg.addr;
				if (rcv_bad) begin
					// sticky, sink stops acking
					err <= 1'b1;
					running <= 1'b0;
				end else if (exp_addr == ADDR_W'(MAX_ADDR)) begin
					done <= 1'b1;
					running <= 1'b0;
				end else begin
					exp_addr <= exp_addr + 1'b1;
				end
			end
		end
	end

	assign o_leds[LED_RUN] = running;
	assign o_leds[LED_DONE] = done;
	assign o_leds[LED_ERR] = err;
	assign o_leds[LED_FULL] = full_seen;

	// address split in nibbles, idle pattern while dark
	assign last_wide = {{(DATA_W-ADDR_W){1'b0}}, last_addr};
	assign o_digit0 = (o_leds == '0) ? IDLE_DIGIT : last_wide[3:0];
	assign o_digit1 = (o_leds == '0) ? IDLE_DIGIT : last_wide[7:4];

endmodule

// File: logic/seg7_encode.sv
module seg7_encode (
	input  logic       i_clk,
	input  logic [3:0] i_digit,
	output logic [6:0] o_seg_n
);

	// bit 6 is segment a, bit 0 is segment g
	logic [6:0] seg;

	// active high pattern per hex digit
	always_comb begin
		case (i_digit)
			4'h0: seg = 7'h7E;
			4'h1: seg = 7'h30;
			4'h2: seg = 7'h6D;
			4'h3: seg = 7'h79;
			4'h4: seg = 7'h33;
			4'h5: seg = 7'h5B;
			4'h6: seg = 7'h5F;
			4'h7: seg = 7'h70;
			4'h8: seg = 7'h7F;
			4'h9: seg = 7'h7B;
			4'hA: seg = 7'h77;
			4'hB: seg = 7'h1F;
			4'hC: seg = 7'h4E;
			4'hD: seg = 7'h3D;
			4'hE: seg = 7'h4F;
			default: seg = 7'h47;
		endcase
	end

	// common anode, segment lit when low
	always_ff @(posedge i_clk) begin
		o_seg_n <= ~seg;
	end

endmodule

// File: logic/fifo_test_top.sv
module fifo_test_top #(
	parameter int MIN_ADDR = 0,
	parameter int MAX_ADDR = 55,
	parameter int DEPTH = 4,
	parameter int TICK_DIV = 8
) (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_switch_1,
	input  logic       i_switch_2,
	output logic [6:0] o_segment1,
	output logic [6:0] o_segment2,
	output logic [3:0] o_led
);

	logic tick;
	logic fifo_full;
	logic [3:0] leds;
	logic [3:0] digit0;
	logic [3:0] digit1;

	// tester to fifo, and fifo back to tester
	ns_link_if lnk_out ();
	ns_link_if lnk_in ();

	// step enable for the slow sink
	tick_gen #(
		.TICK_DIV(TICK_DIV)
	) tick_gen_inst (
		.i_clk  (i_clk),
		.i_rst_n(i_rst_n),
		.o_tick (tick)
	);

	// unit under test
	msg_fifo #(
		.DEPTH(DEPTH)
	) msg_fifo_inst (
		.i_clk  (i_clk),
		.i_rst_n(i_rst_n),
		.i_wr   (lnk_out.rcv),
		.o_rd   (lnk_in.snd),
		.o_full (fifo_full)
	);

	fifo_tester #(
		.MIN_ADDR(MIN_ADDR),
		.MAX_ADDR(MAX_ADDR)
	) fifo_tester_inst (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_switch_1(i_switch_1),
		.i_switch_2(i_switch_2),
		.i_tick    (tick),
		.i_full    (fifo_full),
		.o_msg     (lnk_out.snd),
		.i_msg     (lnk_in.rcv),
		.o_leds    (leds),
		.o_digit0  (digit0),
		.o_digit1  (digit1)
	);

	// low nibble on the first display
	seg7_encode seg_lo_inst (
		.i_clk  (i_clk),
		.i_digit(digit0),
		.o_seg_n(o_segment1)
	);

	seg7_encode seg_hi_inst (
		.i_clk  (i_clk),
		.i_digit(digit1),
		.o_seg_n(o_segment2)
	);

	assign o_led = leds;

endmodule

// File: sim/clk_rst_gen.sv
module clk_rst_gen #(
	parameter int PERIOD = 40,
	parameter int RST_CYCLES = 2
) (
	output logic o_clk,
	output logic o_rst_n
);

	// free-running clock, low first
	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD / 2) o_clk = ~o_clk;
		end
	end

	// reset over the first rising edges
	// released on a falling edge, clear of the sampling edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

// File: sim/fifo_test_chk.sv
module fifo_test_chk #(
	parameter int DEPTH = 4
) (
	input logic          i_clk,
	input logic          i_rst_n,
	input ns_pkg::msg_t  i_snd_msg,
	input logic          i_snd_req,
	input logic          i_snd_ack,
	input logic          i_full,
	input ns_pkg::msg_t  i_rcv_msg,
	input logic          i_rcv_req,
	input logic          i_rcv_ack,
	input logic          i_running,
	input logic          i_corrupt,
	input logic          i_restart,
	input logic [3:0]    i_leds
);
	import ns_pkg::*;

	// read by the testbench top at the end
	int fail_cnt = 0;

	logic corrupt_sent;
	logic [7:0] exp_data;
	logic [3:0] exp_redun;
	logic rule_ok;
	logic in_xfer;
	logic out_xfer;
	// messages inside the fifo, counted from both links
	int occ;

	// a corrupted message went into the fifo since the last restart
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			corrupt_sent <= 1'b0;
		end else if (i_restart) begin
			corrupt_sent <= 1'b0;
		end else if (i_snd_req && i_snd_ack && i_corrupt) begin
			corrupt_sent <= 1'b1;
		end
	end

	assign in_xfer = i_snd_req && i_snd_ack;
	assign out_xfer = i_rcv_req && i_rcv_ack;

	// occupancy model from the link transfers
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			occ <= 0;
		end else begin
			occ <= occ + int'(in_xfer) - int'(out_xfer);
		end
	end

	// address padded to a byte, xor 5A; redundancy is nibble xor
	assign exp_data = {2'b00, i_rcv_msg.addr} ^ 8'h5A;
	assign exp_redun = i_rcv_msg.data[7:4] ^ i_rcv_msg.data[3:0];
	assign rule_ok = (i_rcv_msg.data == exp_data) && (i_rcv_msg.redun == exp_redun);

	// tester side holds its message until the fifo takes it
	snd_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_snd_req && !i_snd_ack |=> i_snd_req && $stable(i_snd_msg))
		else begin
			$error("tester message changed while waiting for ack");
			fail_cnt = fail_cnt + 1;
		end

	// fifo head held the same way
	rcv_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_rcv_req && !i_rcv_ack |=> i_rcv_req && $stable(i_rcv_msg))
		else begin
			$error("fifo head changed while waiting for ack");
			fail_cnt = fail_cnt + 1;
		end

	// with DEPTH messages in flight the fifo is full and refuses writes
	no_ack_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(occ == DEPTH) |-> i_full && !i_snd_ack)
		else begin
			$error("fifo acked a write or missed full with every slot taken");
			fail_cnt = fail_cnt + 1;
		end

	// only a corrupted run may deliver a bad message
	clean_rule: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_rcv_req && i_rcv_ack && i_running && !corrupt_sent |-> rule_ok)
		else begin
			$error("clean message broke the data or redundancy rule");
			fail_cnt = fail_cnt + 1;
		end

	done_xor_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_leds[LED_DONE] && i_leds[LED_ERR]))
		else begin
			$error("done and error leds lit together");
			fail_cnt = fail_cnt + 1;
		end

endmodule

// fifo write side is seen at the tester's ports
bind fifo_tester fifo_test_chk chk_inst (
	.i_clk    (i_clk),
	.i_rst_n  (i_rst_n),
	.i_snd_msg(o_msg.msg),
	.i_snd_req(o_msg.req),
	.i_snd_ack(o_msg.ack),
	.i_full   (i_full),
	.i_rcv_msg(i_msg.msg),
	.i_rcv_req(i_msg.req),
	.i_rcv_ack(i_msg.ack),
	.i_running(running),
	.i_corrupt(corrupt_cur),
	.i_restart(restart),
	.i_leds   (o_leds)
);

// File: sim/fifo_test_tb.sv
module fifo_test_tb;
	import ns_pkg::*;

	localparam int PERIOD = 40;
	localparam int TICK_DIV = 8;
	localparam int MSG_COUNT = 56;
	// four runs, twice over
	localparam int WATCHDOG_TIME = 4 * MSG_COUNT * TICK_DIV * PERIOD * 2;
	// one run with margin, in cycles
	localparam int RUN_CYCLES = MSG_COUNT * TICK_DIV * 2;
	// active low, bit 6 is segment a
	localparam logic [6:0] SEG_N_A = 7'h08;
	localparam logic [6:0] SEG_N_7 = 7'h0F;
	localparam logic [6:0] SEG_N_3 = 7'h06;
	localparam logic [3:0] RUN_MASK = 4'b1 << LED_RUN;
	localparam logic [3:0] END_MASK = (4'b1 << LED_DONE) | (4'b1 << LED_ERR);
	// full and done lit, run and error dark
	localparam logic [3:0] LEDS_DONE = (4'b1 << LED_FULL) | (4'b1 << LED_DONE);

	logic clk;
	logic rst_n;
	logic switch_1;
	logic switch_2;
	logic [6:0] segment1;
	logic [6:0] segment2;
	logic [3:0] led;
	int errors;
	int tests;
	int tests_failed;
	int mark;
	int delay;
	integer seed;

	clk_rst_gen #(
		.PERIOD    (PERIOD),
		.RST_CYCLES(2)
	) clk_rst_gen_inst (
		.o_clk  (clk),
		.o_rst_n(rst_n)
	);

	fifo_test_top fifo_test_top_inst (
		.i_clk     (clk),
		.i_rst_n   (rst_n),
		.i_switch_1(switch_1),
		.i_switch_2(switch_2),
		.o_segment1(segment1),
		.o_segment2(segment2),
		.o_led     (led)
	);

	// own errors plus the bound assertions
	function automatic int failures();
		return errors + fifo_test_top_inst.fifo_tester_inst.chk_inst.fail_cnt;
	endfunction

	task automatic check_value(input string name, input logic [6:0] got,
		input logic [6:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// wait until some masked led matches want, or give up
	task automatic wait_leds(input logic [3:0] mask, input bit want, input int limit,
		input string what);
		int n;
		n = 0;
		while ((((led & mask) != 0) != want) && (n < limit)) begin
			@(negedge clk);
			n++;
		end
		if (((led & mask) != 0) != want) begin
			$display("timeout after %0d cycles waiting for %s", limit, what);
			errors++;
		end
	endtask

	// hold a switch for a few cycles, longer than sync plus edge detect
	task automatic press(input int which);
		@(negedge clk);
		if (which == 1) begin
			switch_1 = 1'b1;
		end else begin
			switch_2 = 1'b1;
		end
		repeat (4) @(negedge clk);
		switch_1 = 1'b0;
		switch_2 = 1'b0;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (failures() == mark) begin
			$display("test %0d %s: pass", tests, name);
		end else begin
			$display("test %0d %s: fail", tests, name);
			tests_failed++;
		end
		mark = failures();
	endtask

	initial begin
		switch_1 = 1'b0;
		switch_2 = 1'b0;
		errors = 0;
		tests = 0;
		tests_failed = 0;
		mark = 0;
		seed = 32;
		wait (rst_n === 1'b1);

		// idle display straight out of reset
		check_value("o_led", led, 4'h0);
		check_value("o_segment1", segment1, SEG_N_A);
		check_value("o_segment2", segment2, SEG_N_A);
		wait_leds(RUN_MASK, 1'b1, 10, "LED_RUN after reset");
		finish_test("reset and start");

		wait_leds(END_MASK, 1'b1, RUN_CYCLES, "end of clean run");
		check_value("o_led", led, LEDS_DONE);
		finish_test("clean run");

		// segments lag the digits by one cycle
		@(negedge clk);
		check_value("o_segment1", segment1, SEG_N_7);
		check_value("o_segment2", segment2, SEG_N_3);
		finish_test("last address on display");

		// corrupt one message somewhere in a fresh run
		press(2);
		wait_leds(RUN_MASK, 1'b1, 20, "LED_RUN after restart");
		delay = 20 + ($unsigned($random(seed)) % 200);
		repeat (delay) @(negedge clk);
		press(1);
		wait_leds(END_MASK, 1'b1, RUN_CYCLES, "end of corrupted run");
		check_value("o_led[LED_ERR]", led[LED_ERR], 1'b1);
		repeat (50) begin
			check_value("o_led[LED_DONE]", led[LED_DONE], 1'b0);
			@(negedge clk);
		end
		finish_test("corruption detected");

		// restart clears the error, then a clean rerun
		press(2);
		wait_leds(END_MASK, 1'b0, 20, "status clear after restart");
		check_value("o_led[LED_ERR]", led[LED_ERR], 1'b0);
		check_value("o_led[LED_DONE]", led[LED_DONE], 1'b0);
		wait_leds(RUN_MASK, 1'b1, RUN_CYCLES, "LED_RUN after flush");
		wait_leds(END_MASK, 1'b1, RUN_CYCLES, "end of rerun");
		check_value("o_led", led, LEDS_DONE);
		finish_test("restart and rerun");

		$display("tests %0d, failed %0d, check errors %0d", tests, tests_failed, failures());
		if ((failures() == 0) && (tests_failed == 0)) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// hard stop if a run never ends
	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog expired before all tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: flist.f
logic/ns_pkg.sv
logic/ns_link_if.sv
logic/tick_gen.sv
logic/msg_fifo.sv
logic/fifo_tester.sv
logic/seg7_encode.sv
logic/fifo_test_top.sv
sim/clk_rst_gen.sv
sim/fifo_test_chk.sv
sim/fifo_test_tb.sv
